// File: common/ccuPkg.sv
// Shared widths, opcodes and configuration layouts of the configuration control unit.
// Instruction words are 128 bits, and the opcode sits in bits 7..0 of the first word.
// Each target struct is taken from the collected words starting at bit 8.
// Bits above a struct are ignored. They include the old bank flag fields.
`default_nettype none

package ccuPkg;

    // ========================================================================
    // Widths and encodings
    // ========================================================================
    localparam int IsaWidth      = 128;
    localparam int OpcodeWidth   = 8;
    localparam int AddrWidth     = 16;
    localparam int ByteWidth     = 8;
    localparam int DramAddrWidth = 32;

    localparam int OpKnn = 2;
    localparam int OpSya = 3;
    localparam int OpGic = 5;

    localparam int WordsKnn = 2;
    localparam int WordsSya = 3;
    localparam int WordsGic = 2;

    // Collector slots, one per kept target
    localparam int NumTargets = 3;
    localparam int TgtKnn     = 0;
    localparam int TgtSya     = 1;
    localparam int TgtGic     = 2;

    typedef logic [IsaWidth-1:0]      isaWordT;
    typedef logic [OpcodeWidth-1:0]   opcodeT;
    typedef logic [AddrWidth-1:0]     addrT;   // GLB address or count
    typedef logic [ByteWidth-1:0]     byteT;
    typedef logic [DramAddrWidth-1:0] dramAddrT;

    typedef enum logic {
        Idle,
        Decode
    } seqStateT;

    // ========================================================================
    // Target configuration structs, MSB field first
    // ========================================================================
    typedef struct packed {
        addrT mapWrAddr;
        addrT crdRdAddr;
        byteT k;
        addrT nip;          // Lowest field, right above the opcode
    } knnCfgT;

    typedef struct packed {
        addrT ofmWrBaseAddr;
        addrT wgtRdBaseAddr;
        addrT actRdBaseAddr;
        byteT lopOrd;
        addrT numTilIfm;
        addrT numTilFlt;
        addrT numGrpPerTile;
        addrT chn;
        byteT zp;
        byteT shift;
        byteT ofmPhaseShift;
        byteT mode;
    } syaCfgT;

    typedef struct packed {
        addrT     num;
        addrT     glbBaseAddr;
        dramAddrT dramBaseAddr;
        byteT     inOut;    // 0 loads into the chip, 1 writes back to DRAM
    } gicCfgT;

endpackage

`default_nettype wire

// File: ccu/isaCollector.sv
// Serial-in parallel-out collector for a fixed count of instruction words.
// Word k of an instruction ends up at bits IsaWidth*k and up of outDat.
// Once full, outDat and outVld hold until the outVld/outRdy handshake or a flush.
// The driver must not raise inVld while inRdy is low.
`timescale 1ns/1ns
`default_nettype none

module isaCollector #(
    parameter int NumWords = 2
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 flush,
    input  logic                                 inVld,
    input  ccuPkg::isaWordT                      inDat,
    output logic                                 inRdy,
    output logic [NumWords*ccuPkg::IsaWidth-1:0] outDat,
    output logic                                 outVld,
    input  logic                                 outRdy
);
    import ccuPkg::*;

    localparam int CntWidth = $clog2(NumWords + 1);
    localparam logic [CntWidth-1:0] FullCnt = CntWidth'(NumWords);

    logic [CntWidth-1:0]              wordCnt;
    logic [NumWords*IsaWidth-1:0]     shiftReg;
    logic [(NumWords+1)*IsaWidth-1:0] shiftNext;

    assign outVld = (wordCnt == FullCnt);
    assign inRdy  = !outVld;
    assign outDat = shiftReg;

    // New word enters at the top, older words move down one slot
    assign shiftNext = {inDat, shiftReg};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wordCnt <= '0;
        end else if (flush || (outVld && outRdy)) begin
            wordCnt <= '0;
        end else if (inVld && inRdy) begin
            wordCnt <= wordCnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (inVld && inRdy) begin
            shiftReg <= shiftNext[(NumWords+1)*IsaWidth-1:IsaWidth];
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================
    // Sequencer must honour the full flag
    inVldWhileFull: assert property (@(posedge clk) disable iff (!rst_n)
        inVld |-> inRdy);

    // Payload and valid must hold under a stalled target
    outDatHeld: assert property (@(posedge clk) disable iff (!rst_n)
        (outVld && !outRdy) |=> (outVld && $stable(outDat)));

endmodule

`default_nettype wire

// File: ccu/ccuSequencer.sv
// Idle/Decode sequencer of the configuration control unit.
// Latches the opcode of the first word in Idle, then steers words to one collector.
// The opcode word stays on the bus in Idle and is consumed in Decode.
// An unknown opcode consumes only the first word and then returns to Idle.
// Only one instruction is in flight at a time.
`timescale 1ns/1ns
`default_nettype none

module ccuSequencer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          isaVld,
    input  ccuPkg::opcodeT                isaOpcode,
    output logic                          isaRdy,
    input  logic [ccuPkg::NumTargets-1:0] colInRdy,
    input  logic [ccuPkg::NumTargets-1:0] colOutVld,
    input  logic [ccuPkg::NumTargets-1:0] cfgRdy,
    output logic [ccuPkg::NumTargets-1:0] colWordVld,
    output logic                          flush
);
    import ccuPkg::*;

    seqStateT              state;
    seqStateT              stateNxt;
    opcodeT                opcodeQ;
    logic [NumTargets-1:0] tgtSel;      // One-hot, all zero when unknown
    logic                  knownOp;
    logic                  inDecode;
    logic                  cfgDone;
    logic                  unkDone;

    // ========================================================================
    // Opcode decode
    // ========================================================================
    always_comb begin
        tgtSel = '0;
        case (opcodeQ)
            opcodeT'(OpKnn): tgtSel[TgtKnn] = 1'b1;
            opcodeT'(OpSya): tgtSel[TgtSya] = 1'b1;
            opcodeT'(OpGic): tgtSel[TgtGic] = 1'b1;
            default:         tgtSel = '0;
        endcase
    end

    assign knownOp  = |tgtSel;
    assign inDecode = (state == Decode);

    // Ready follows the selected collector; unknown opcode takes a single word
    assign isaRdy     = inDecode && (knownOp ? |(tgtSel & colInRdy) : 1'b1);
    assign colWordVld = {NumTargets{inDecode && isaVld}} & tgtSel & colInRdy;
    assign flush      = !inDecode;

    assign cfgDone = knownOp && |(tgtSel & colOutVld & cfgRdy);   // Target handshake
    assign unkDone = !knownOp && isaVld;                           // Opcode word dropped

    // ========================================================================
    // FSM
    // ========================================================================
    always_comb begin
        stateNxt = state;
        case (state)
            Idle: begin
                if (isaVld) begin
                    stateNxt = Decode;
                end
            end
            Decode: begin
                if (cfgDone || unkDone) begin
                    stateNxt = Idle;
                end
            end
            default: stateNxt = Idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= Idle;
        end else begin
            state <= stateNxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opcodeQ <= '0;
        end else if (state == Idle && isaVld) begin
            opcodeQ <= isaOpcode;   // Low byte of the first word
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================
    // Handshake drops back to Idle, where no word is taken
    idleAfterCfg: assert property (@(posedge clk) disable iff (!rst_n)
        |(colOutVld & cfgRdy) |=> (state == Idle) && !isaRdy);

    // Collectors never present two configurations at once
    singleCfgVld: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(colOutVld));

endmodule

`default_nettype wire

// File: ccu/ccuTop.sv
// Top level of the configuration control unit for KNN, SYA and GIC.
// One instruction is decoded at a time. Its target valid holds until that target is ready.
// Configuration structs are sliced from the collected words starting at bit 8.
// Bits above each struct are ignored.
`timescale 1ns/1ns
`default_nettype none

module ccuTop (
    input  logic            clk,
    input  logic            rst_n,

    input  ccuPkg::isaWordT isaDat,
    input  logic            isaVld,
    output logic            isaRdy,

    output ccuPkg::knnCfgT  knnCfg,
    output logic            knnCfgVld,
    input  logic            knnCfgRdy,

    output ccuPkg::syaCfgT  syaCfg,
    output logic            syaCfgVld,
    input  logic            syaCfgRdy,

    output ccuPkg::gicCfgT  gicCfg,
    output logic            gicCfgVld,
    input  logic            gicCfgRdy
);
    import ccuPkg::*;

    logic [NumTargets-1:0]        colInRdy;
    logic [NumTargets-1:0]        colOutVld;
    logic [NumTargets-1:0]        colWordVld;
    logic [NumTargets-1:0]        cfgRdy;
    logic                         flush;
    logic [WordsKnn*IsaWidth-1:0] knnBits;
    logic [WordsSya*IsaWidth-1:0] syaBits;
    logic [WordsGic*IsaWidth-1:0] gicBits;

    assign cfgRdy[TgtKnn] = knnCfgRdy;
    assign cfgRdy[TgtSya] = syaCfgRdy;
    assign cfgRdy[TgtGic] = gicCfgRdy;

    ccuSequencer seq0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .isaVld     (isaVld),
        .isaOpcode  (isaDat[OpcodeWidth-1:0]),
        .isaRdy     (isaRdy),
        .colInRdy   (colInRdy),
        .colOutVld  (colOutVld),
        .cfgRdy     (cfgRdy),
        .colWordVld (colWordVld),
        .flush      (flush)
    );

    // ========================================================================
    // Collectors, one per target
    // ========================================================================
    isaCollector #(.NumWords(WordsKnn)) knnCol (
        .clk    (clk),
        .rst_n  (rst_n),
        .flush  (flush),
        .inVld  (colWordVld[TgtKnn]),
        .inDat  (isaDat),
        .inRdy  (colInRdy[TgtKnn]),
        .outDat (knnBits),
        .outVld (colOutVld[TgtKnn]),
        .outRdy (knnCfgRdy)
    );

    isaCollector #(.NumWords(WordsSya)) syaCol (
        .clk    (clk),
        .rst_n  (rst_n),
        .flush  (flush),
        .inVld  (colWordVld[TgtSya]),
        .inDat  (isaDat),
        .inRdy  (colInRdy[TgtSya]),
        .outDat (syaBits),
        .outVld (colOutVld[TgtSya]),
        .outRdy (syaCfgRdy)
    );

    isaCollector #(.NumWords(WordsGic)) gicCol (
        .clk    (clk),
        .rst_n  (rst_n),
        .flush  (flush),
        .inVld  (colWordVld[TgtGic]),
        .inDat  (isaDat),
        .inRdy  (colInRdy[TgtGic]),
        .outDat (gicBits),
        .outVld (colOutVld[TgtGic]),
        .outRdy (gicCfgRdy)
    );

    // ========================================================================
    // Field unpack, opcode byte skipped
    // ========================================================================
    assign knnCfg = knnBits[OpcodeWidth +: $bits(knnCfgT)];   // 56 of 248 bits used
    assign syaCfg = syaBits[OpcodeWidth +: $bits(syaCfgT)];   // Spans words 0 and 1
    assign gicCfg = gicBits[OpcodeWidth +: $bits(gicCfgT)];

    assign knnCfgVld = colOutVld[TgtKnn];
    assign syaCfgVld = colOutVld[TgtSya];
    assign gicCfgVld = colOutVld[TgtGic];

endmodule

`default_nettype wire

// File: tests/ccuTb.sv
// Testbench for ccuTop with random KNN, SYA, GIC and unknown-opcode instructions.
// Inputs change on the falling edge, and checks sample on the rising edge.
// Expected structs are packed by the bit-8 rule and queued per target.
// Run with assertions enabled, since they do the checking.
`timescale 1ns/1ns
`default_nettype none

module ccuTb;
    import ccuPkg::*;

    localparam int Seed          = 80771;
    localparam int NumInstr      = 40;
    localparam int TimeoutCycles = 2000;   // 40 x (3 + 8 + 3) cycles plus reset, rounded up

    logic    clk = 1'b0;
    logic    rst_n;
    isaWordT isaDat;
    logic    isaVld;
    logic    isaRdy;
    knnCfgT  knnCfg;
    syaCfgT  syaCfg;
    gicCfgT  gicCfg;
    logic    knnCfgVld;
    logic    syaCfgVld;
    logic    gicCfgVld;
    logic    knnCfgRdy = 1'b0;
    logic    syaCfgRdy = 1'b0;
    logic    gicCfgRdy = 1'b0;
    logic    anyVld;

    integer  seed      = Seed;
    integer  stallSeed = Seed;
    int      cycleCnt  = 0;
    int      cfgCnt    = 0;
    int      unkCnt    = 0;
    int      mismatchCnt = 0;   // Data compare errors
    int      protoCnt  = 0;     // Handshake rule errors
    int      flowCnt   = 0;     // Sequencing errors seen by the driver
    knnCfgT  knnQ[$];
    syaCfgT  syaQ[$];
    gicCfgT  gicQ[$];
    knnCfgT  knnExp;
    syaCfgT  syaExp;
    gicCfgT  gicExp;

    assign anyVld = knnCfgVld || syaCfgVld || gicCfgVld;

    ccuTop dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .isaDat    (isaDat),
        .isaVld    (isaVld),
        .isaRdy    (isaRdy),
        .knnCfg    (knnCfg),
        .knnCfgVld (knnCfgVld),
        .knnCfgRdy (knnCfgRdy),
        .syaCfg    (syaCfg),
        .syaCfgVld (syaCfgVld),
        .syaCfgRdy (syaCfgRdy),
        .gicCfg    (gicCfg),
        .gicCfgVld (gicCfgVld),
        .gicCfgRdy (gicCfgRdy)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    // ========================================================================
    // Stimulus
    // ========================================================================
    // Holds one word on the bus until the edge that takes it
    task automatic sendWord(input isaWordT w);
        logic taken;
        isaDat = w;
        isaVld = 1'b1;
        taken  = 1'b0;
        while (!taken) begin
            taken = isaRdy;     // Registered only, stable until the next rising edge
            @(negedge clk);
        end
        isaVld = 1'b0;
    endtask

    task automatic sendInstr();
        int                    kind;
        int                    nWords;
        logic                  unknown;
        opcodeT                op;
        logic [3*IsaWidth-1:0] bits;
        logic [159:0]          rnd;
        knnCfgT                kc;
        syaCfgT                sc;
        gicCfgT                gc;
        for (int i = 0; i < 12; i++) begin
            bits[32*i +: 32] = $random(seed);   // Ignored bits get noise too
        end
        for (int i = 0; i < 5; i++) begin
            rnd[32*i +: 32] = $random(seed);
        end
        kind    = {$random(seed)} % 8;
        unknown = 1'b0;
        if (kind < 2) begin
            op     = opcodeT'(OpKnn);
            nWords = WordsKnn;
            kc     = rnd[$bits(knnCfgT)-1:0];
            bits[OpcodeWidth +: $bits(knnCfgT)] = kc;
            knnQ.push_back(kc);
        end else if (kind < 5) begin
            op     = opcodeT'(OpSya);
            nWords = WordsSya;
            sc     = rnd[$bits(syaCfgT)-1:0];
            bits[OpcodeWidth +: $bits(syaCfgT)] = sc;
            syaQ.push_back(sc);
        end else if (kind < 7) begin
            op     = opcodeT'(OpGic);
            nWords = WordsGic;
            gc     = rnd[$bits(gicCfgT)-1:0];
            bits[OpcodeWidth +: $bits(gicCfgT)] = gc;
            gicQ.push_back(gc);
        end else begin
            op      = 8'($random(seed)) | 8'h08;  // Bit 3 set, never 2, 3 or 5
            nWords  = 1;
            unknown = 1'b1;
            unkCnt++;
        end
        bits[OpcodeWidth-1:0] = op;
        for (int w = 0; w < nWords; w++) begin
            if ({$random(seed)} % 4 == 0) begin
                isaVld = 1'b0;
                repeat ({$random(seed)} % 3 + 1) @(negedge clk);
            end
            sendWord(bits[IsaWidth*w +: IsaWidth]);
        end
        // One word only, then back in Idle with nothing raised
        if (unknown) begin
            assert (!isaRdy && !anyVld) else begin
                flowCnt++;
                $display("Unknown opcode %h at %0t was not dropped after one word", op, $time);
            end
        end
    endtask

    // Random back-pressure on every target
    always @(negedge clk) begin
        if (!rst_n) begin
            knnCfgRdy = 1'b0;
            syaCfgRdy = 1'b0;
            gicCfgRdy = 1'b0;
        end else begin
            knnCfgRdy = ({$random(stallSeed)} % 3 != 0);
            syaCfgRdy = ({$random(stallSeed)} % 3 != 0);
            gicCfgRdy = ({$random(stallSeed)} % 3 != 0);
        end
    end

    initial begin
        int drainCnt;
        rst_n  = 1'b0;
        isaVld = 1'b0;
        isaDat = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        for (int n = 0; n < NumInstr; n++) begin
            sendInstr();
        end
        drainCnt = 0;
        while ((knnQ.size() + syaQ.size() + gicQ.size() != 0) && drainCnt < 100) begin
            @(negedge clk);
            drainCnt++;
        end
        if (knnQ.size() + syaQ.size() + gicQ.size() != 0) begin
            flowCnt++;
            $display("Expected configurations left over: knn %0d, sya %0d, gic %0d",
                knnQ.size(), syaQ.size(), gicQ.size());
        end
        $display("Checked %0d configs, %0d unknown opcodes; mismatches %0d, protocol %0d, flow %0d",
            cfgCnt, unkCnt, mismatchCnt, protoCnt, flowCnt);
        if (mismatchCnt + protoCnt + flowCnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycleCnt++;
        if (cycleCnt >= TimeoutCycles) begin
            $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================
    always @(posedge clk) begin
        if (rst_n && knnCfgVld && knnCfgRdy) begin
            if (knnQ.size() == 0) begin
                mismatchCnt++;
                $display("KNN handshake at %0t with no KNN instruction pending", $time);
            end else begin
                knnExp = knnQ.pop_front();
                cfgCnt++;
                assert (knnCfg == knnExp) else begin
                    mismatchCnt++;
                    $display("Mismatch at %0t: knnCfg expected %h actual %h", $time, knnExp, knnCfg);
                end
            end
        end
        if (rst_n && syaCfgVld && syaCfgRdy) begin
            if (syaQ.size() == 0) begin
                mismatchCnt++;
                $display("SYA handshake at %0t with no SYA instruction pending", $time);
            end else begin
                syaExp = syaQ.pop_front();
                cfgCnt++;
                assert (syaCfg == syaExp) else begin
                    mismatchCnt++;
                    $display("Mismatch at %0t: syaCfg expected %h actual %h", $time, syaExp, syaCfg);
                end
            end
        end
        if (rst_n && gicCfgVld && gicCfgRdy) begin
            if (gicQ.size() == 0) begin
                mismatchCnt++;
                $display("GIC handshake at %0t with no GIC instruction pending", $time);
            end else begin
                gicExp = gicQ.pop_front();
                cfgCnt++;
                assert (gicCfg == gicExp) else begin
                    mismatchCnt++;
                    $display("Mismatch at %0t: gicCfg expected %h actual %h", $time, gicExp, gicCfg);
                end
            end
        end
    end

    knnHeld: assert property (@(posedge clk) disable iff (!rst_n)
        (knnCfgVld && !knnCfgRdy) |=> (knnCfgVld && $stable(knnCfg)))
        else begin
            protoCnt++;
            $display("At %0t knnCfg or its valid changed while stalled", $time);
        end

    syaHeld: assert property (@(posedge clk) disable iff (!rst_n)
        (syaCfgVld && !syaCfgRdy) |=> (syaCfgVld && $stable(syaCfg)))
        else begin
            protoCnt++;
            $display("At %0t syaCfg or its valid changed while stalled", $time);
        end

    gicHeld: assert property (@(posedge clk) disable iff (!rst_n)
        (gicCfgVld && !gicCfgRdy) |=> (gicCfgVld && $stable(gicCfg)))
        else begin
            protoCnt++;
            $display("At %0t gicCfg or its valid changed while stalled", $time);
        end

    // A pending config blocks the instruction input
    inputBlocked: assert property (@(posedge clk) disable iff (!rst_n)
        anyVld |-> (!isaRdy && $onehot0({knnCfgVld, syaCfgVld, gicCfgVld})))
        else begin
            protoCnt++;
            $display("At %0t isaRdy was high or several valids were high together", $time);
        end

    resetQuiet: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> (!isaRdy && !anyVld))
        else begin
            protoCnt++;
            $display("At %0t isaRdy or a target valid was high around reset", $time);
        end

endmodule

`default_nettype wire

// File: build.f
common/ccuPkg.sv
ccu/isaCollector.sv
ccu/ccuSequencer.sv
ccu/ccuTop.sv
tests/ccuTb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f build.f --top-module ccuTb -o ccuSim

status=0
out=$(./obj_dir/ccuSim) || status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    exit 1
fi
echo "$out" | grep -q "All tests passed"
